// File: project.f
verilog/bp_pkg.sv
verilog/wb_pkg.sv
verilog/target_ram.sv
verilog/branch_predictor.sv
verilog/fetch_pc_gen.sv
verilog/packet_fifo.sv
verilog/wb_branch_port.sv
verilog/frontend_top.sv
verif/frontend_props.sv
verif/frontend_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f project.f \
        --top-module frontend_tb -o frontend_sim \
    && ./obj_dir/frontend_sim \
    || exit 1

// File: verif/frontend_tb.sv
// fetch front end testbench: lfsr branch program, wishbone master, reference model and checks
`timescale 1ns/100ps

module frontend_tb;
    import bp_pkg::*;
    import wb_pkg::*;

    localparam int n_steps         = 300;
    localparam int cycles_per_step = 12;
    localparam int reset_cycles    = 8;
    localparam int timeout_cycles  = n_steps * cycles_per_step + reset_cycles;
    localparam int n_branches      = 6;

    logic             clk;
    logic             rstn;
    logic             cyc;
    logic             stb;
    logic             we;
    logic [wb_aw-1:0] adr;
    logic [wb_dw-1:0] dat_w;
    logic [wb_dw-1:0] dat_r;
    logic             ack;

    logic [15:0]     lfsr = 16'd4529;
    logic [pc_w-1:0] br_pc [0:n_branches-1];
    logic [pc_w-1:0] br_tgt [0:n_branches-1];
    logic            br_always [0:n_branches-1];
    logic            model_valid [0:(1 << index_w)-1];  // mirror of the btb mask
    logic [pc_w-1:0] model_tgt [0:(1 << index_w)-1];
    int              cycle_count = 0;

    frontend_top dut (
        .clk   (clk),
        .rstn  (rstn),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout: bus access never acknowledged");
        end
    end

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    // expected next fetch group after resolving pc
    function automatic logic [pc_w-1:0] real_next(input logic [pc_w-1:0] pc, input logic taken);
        int i;
        real_next = pc + group_bytes;
        for (i = 0; i < n_branches; i++) begin
            if (taken && br_pc[i] == pc)
                real_next = br_tgt[i];
        end
    endfunction

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %h actual %h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "check %s failed", name);
        end
    endtask

    // two rings of three branches, the conditional one closes each ring
    task automatic build_program();
        logic [15:0]     v;
        logic [pc_w-1:0] cand;
        logic            dup;
        int              i;
        int              j;
        int              hi;
        hi = 0;
        for (i = 0; i < n_branches; i++) begin
            do begin
                take_bits(7, v);
                cand = reset_pc + 32'(1 + int'(v[6:0]) % 95) * group_bytes;
                dup = 1'b0;
                for (j = 0; j < i; j++) begin
                    if (br_pc[j] == cand)
                        dup = 1'b1;
                end
            end while (dup);
            br_pc[i] = cand;
            if (cand > br_pc[hi])
                hi = i;
        end
        for (i = 0; i < n_branches; i++) begin
            br_always[i] = (i % 3) != 2;
            br_tgt[i]    = (i % 3 == 2) ? br_pc[i-2] : br_pc[i+1];
        end
        br_always[hi] = 1'b1;   // highest branch loops back to the start
        br_tgt[hi]    = reset_pc;
    endtask

    task automatic resolve_taken(input logic [pc_w-1:0] pc, output logic taken);
        logic [15:0] v;
        int          i;
        taken = 1'b0;
        for (i = 0; i < n_branches; i++) begin
            if (br_pc[i] == pc) begin
                take_bits(1, v);
                taken = br_always[i] ? 1'b1 : v[0];
            end
        end
    endtask

    // caller sits on a rising edge
    task automatic bus_access(input logic wr, input logic [wb_aw-1:0] a,
                              input logic [wb_dw-1:0] wdata, output logic [wb_dw-1:0] rdata);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= wr;
        adr   <= a;
        dat_w <= wdata;
        do
            @(negedge clk);
        while (!ack);
        rdata = dat_r;
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        @(negedge clk);
        check_equal("ack width", 32'd0, {31'd0, ack});
        @(posedge clk);
    endtask

    initial begin : main_seq
        logic [wb_dw-1:0]   rd_pc;
        logic [wb_dw-1:0]   rd_pred;
        logic [wb_dw-1:0]   rd_dummy;
        logic [pc_w-1:0]    head_pc;
        logic               head_taken;
        logic [pc_w-1:0]    exp_pc;
        logic [pc_w-1:0]    exp_pred;
        logic [pc_w-1:0]    pred_next;
        logic [pc_w-1:0]    next_pc;
        logic               taken;
        logic [index_w-1:0] idx;
        int                 step;
        int                 redirects;
        int                 taken_run;
        int                 i;
        clk   = 1'b0;
        rstn  = 1'b0;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        for (i = 0; i < (1 << index_w); i++)
            model_valid[i] = 1'b0;
        build_program();
        exp_pc    = reset_pc;
        redirects = 0;
        taken_run = 0;
        repeat (reset_cycles) @(posedge clk);
        rstn <= 1'b1;

        bus_access(1'b0, 4'hf, '0, rd_dummy);
        check_equal("unmapped read", 32'd0, rd_dummy);

        for (step = 0; step < n_steps; step++) begin
            bus_access(1'b0, reg_pc, '0, rd_pc);
            bus_access(1'b0, reg_pred, '0, rd_pred);
            head_pc    = {rd_pc[pc_w-1:1], 1'b0};
            head_taken = rd_pc[0];
            idx        = head_pc[index_lsb +: index_w];
            exp_pred   = model_valid[idx] ? model_tgt[idx] : head_pc + group_bytes;
            check_equal("head pc", exp_pc, head_pc);
            check_equal("pred pc", exp_pred, rd_pred);
            if (step == 0)
                check_equal("first pred_taken", 32'd0, {31'd0, head_taken});
            // long taken run leaves both machines on taken
            if (taken_run >= 8)
                check_equal("pred_taken after taken run", 32'd1, {31'd0, head_taken});

            resolve_taken(head_pc, taken);
            next_pc = real_next(head_pc, taken);
            bus_access(1'b1, reg_outcome, {next_pc[pc_w-1:1], taken}, rd_dummy);

            if (taken && next_pc != exp_pred) begin
                model_valid[idx] = 1'b1;
                model_tgt[idx]   = next_pc;
            end
            taken_run = taken ? taken_run + 1 : 0;
            pred_next = head_taken ? exp_pred : head_pc + group_bytes;
            exp_pc    = next_pc;
            if (pred_next != next_pc) begin
                redirects++;
                if (redirects % 2 == 0)
                    repeat (2) @(posedge clk);  // odd ones read an empty queue
            end
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: verif/frontend_props.sv
// front end properties: wishbone handshake, queue push guard and redirect pulse width
`timescale 1ns/100ps

module frontend_props (
    input logic clk,
    input logic rstn,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic redirect,
    input logic push,
    input logic full,
    input logic flush
);

    ack_in_cycle: assert property (@(posedge clk) disable iff (!rstn) ack |-> cyc && stb)
        else $error("ack raised outside a bus cycle");

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rstn) ack |=> !ack)
        else $error("ack held for more than one cycle");

    // flush clears the queue on the same edge
    push_not_full: assert property (@(posedge clk) disable iff (!rstn) push && full |-> flush)
        else $error("push into a full queue");

    redirect_pulse: assert property (@(posedge clk) disable iff (!rstn) redirect |=> !redirect)
        else $error("redirect longer than one cycle");

endmodule

bind wb_branch_port frontend_props u_port_props (
    .clk      (clk),
    .rstn     (rstn),
    .cyc      (cyc),
    .stb      (stb),
    .ack      (ack),
    .redirect (redirect),
    .push     (1'b0),
    .full     (1'b0),
    .flush    (1'b0)
);

bind packet_fifo frontend_props u_fifo_props (
    .clk      (clk),
    .rstn     (rstn),
    .cyc      (1'b0),
    .stb      (1'b0),
    .ack      (1'b0),
    .redirect (1'b0),
    .push     (push),
    .full     (full),
    .flush    (flush)
);

// File: verilog/frontend_top.sv
// fetch front end top: pc generator, fetch and update queues, wishbone port and predictor
`timescale 1ns/100ps

module frontend_top (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     cyc,
    input  logic                     stb,
    input  logic                     we,
    input  logic [wb_pkg::wb_aw-1:0] adr,
    input  logic [wb_pkg::wb_dw-1:0] dat_w,
    output logic [wb_pkg::wb_dw-1:0] dat_r,
    output logic                     ack
);
    import bp_pkg::*;

    logic [pc_w-1:0] fetch_pc;
    logic [pc_w-1:0] pred_pc;
    logic            pred_taken;
    logic            fq_push;
    fetch_pkt_t      fq_push_data;
    fetch_pkt_t      fq_head;
    logic            fq_pop;
    logic            fq_full;
    logic            fq_empty;
    logic            uq_push;
    update_pkt_t     uq_push_data;
    update_pkt_t     uq_head;
    logic            uq_pop;
    logic            uq_full;
    logic            uq_empty;
    logic            redirect;
    logic [pc_w-1:0] redirect_pc;
    logic            upd_pending;

    assign upd_pending = !uq_empty;

    fetch_pc_gen u_fetch_pc_gen (
        .clk         (clk),
        .rstn        (rstn),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .upd_pending (upd_pending),
        .pred_pc     (pred_pc),
        .pred_taken  (pred_taken),
        .fetch_pc    (fetch_pc),
        .push        (fq_push),
        .push_data   (fq_push_data),
        .full        (fq_full)
    );

    packet_fifo #(.payload_t(fetch_pkt_t)) fetch_q (
        .clk       (clk),
        .rstn      (rstn),
        .push      (fq_push),
        .push_data (fq_push_data),
        .pop       (fq_pop),
        .head      (fq_head),
        .flush     (redirect),
        .full      (fq_full),
        .empty     (fq_empty)
    );

    packet_fifo #(.payload_t(update_pkt_t)) update_q (
        .clk       (clk),
        .rstn      (rstn),
        .push      (uq_push),
        .push_data (uq_push_data),
        .pop       (uq_pop),
        .head      (uq_head),
        .flush     (1'b0),
        .full      (uq_full),
        .empty     (uq_empty)
    );

    wb_branch_port u_wb_branch_port (
        .clk         (clk),
        .rstn        (rstn),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .adr         (adr),
        .dat_w       (dat_w),
        .dat_r       (dat_r),
        .ack         (ack),
        .head        (fq_head),
        .fq_empty    (fq_empty),
        .fq_pop      (fq_pop),
        .uq_full     (uq_full),
        .uq_push     (uq_push),
        .uq_data     (uq_push_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    branch_predictor u_branch_predictor (
        .clk        (clk),
        .rstn       (rstn),
        .fetch_pc   (fetch_pc),
        .pred_pc    (pred_pc),
        .pred_taken (pred_taken),
        .upd_valid  (upd_pending),
        .upd_data   (uq_head),
        .upd_pop    (uq_pop)
    );

endmodule

// File: verilog/wb_branch_port.sv
// wishbone branch port: shows the head packet, resolves outcomes, redirects and queues updates
`timescale 1ns/100ps

module wb_branch_port (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      cyc,
    input  logic                      stb,
    input  logic                      we,
    input  logic [wb_pkg::wb_aw-1:0]  adr,
    input  logic [wb_pkg::wb_dw-1:0]  dat_w,
    output logic [wb_pkg::wb_dw-1:0]  dat_r,
    output logic                      ack,
    input  bp_pkg::fetch_pkt_t        head,
    input  logic                      fq_empty,
    output logic                      fq_pop,
    input  logic                      uq_full,
    output logic                      uq_push,
    output bp_pkg::update_pkt_t       uq_data,
    output logic                      redirect,
    output logic [bp_pkg::pc_w-1:0]   redirect_pc
);
    import bp_pkg::*;
    import wb_pkg::*;

    logic             head_rd;
    logic             out_wr;
    logic             ready;
    logic             accept;
    logic             outcome_ack;
    logic [wb_dw-1:0] wr_data_q;
    logic [pc_w-1:0]  real_next;
    logic             real_taken;
    logic [pc_w-1:0]  pred_next;

    assign head_rd = !we && (adr == reg_pc || adr == reg_pred);
    assign out_wr  = we && (adr == reg_outcome);
    assign ready   = head_rd ? !fq_empty :
                     out_wr  ? (!fq_empty && !uq_full) : 1'b1;
    assign accept  = cyc && stb && !ack && ready;  // !ack keeps ack one cycle wide

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ack         <= 1'b0;
            outcome_ack <= 1'b0;
        end else begin
            ack         <= accept;
            outcome_ack <= accept && out_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wr_data_q <= dat_w;
            if (!we && adr == reg_pc)
                dat_r <= {head.pc[pc_w-1:1], head.pred_taken};
            else if (!we && adr == reg_pred)
                dat_r <= head.pred_pc;
            else
                dat_r <= '0;    // unmapped reads as zero
        end
    end

    // head stays put until the pop at the end of the ack cycle
    assign real_next  = {wr_data_q[pc_w-1:1], 1'b0};
    assign real_taken = wr_data_q[0];
    assign pred_next  = head.pred_taken ? head.pred_pc : head.pc + group_bytes;

    assign uq_data.pc        = head.pc;
    assign uq_data.tpc       = real_next;
    assign uq_data.taken     = real_taken;
    assign uq_data.dir_fail  = (head.pred_taken != real_taken);
    assign uq_data.addr_fail = real_taken && (real_next != head.pred_pc);

    assign fq_pop      = outcome_ack;
    assign uq_push     = outcome_ack;
    assign redirect    = outcome_ack && (pred_next != real_next);
    assign redirect_pc = real_next;

endmodule

// File: verilog/packet_fifo.sv
// packet fifo: small show-ahead queue with flush, payload type set per instance
`timescale 1ns/100ps

module packet_fifo #(
    parameter type payload_t = bp_pkg::fetch_pkt_t
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    input  logic     flush,
    output logic     full,
    output logic     empty
);
    import bp_pkg::*;

    payload_t              mem [0:fifo_depth-1];
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w:0]   count;
    logic                  do_push;
    logic                  do_pop;

    assign full    = (count == (fifo_ptr_w + 1)'(fifo_depth));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];   // show-ahead

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin  // wins over a same-edge push
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (fifo_ptr_w + 1)'(do_push) - (fifo_ptr_w + 1)'(do_pop);
        end
    end

endmodule

// File: verilog/fetch_pc_gen.sv
// fetch pc generator: steps through fetch groups along predictions and fills the fetch queue
`timescale 1ns/100ps

module fetch_pc_gen (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    redirect,
    input  logic [bp_pkg::pc_w-1:0] redirect_pc,
    input  logic                    upd_pending,
    input  logic [bp_pkg::pc_w-1:0] pred_pc,
    input  logic                    pred_taken,
    output logic [bp_pkg::pc_w-1:0] fetch_pc,
    output logic                    push,
    output bp_pkg::fetch_pkt_t      push_data,
    input  logic                    full
);
    import bp_pkg::*;

    logic [pc_w-1:0] next_pc;

    // hold off in reset and while the predictor still owes an update
    assign push = rstn && !redirect && !full && !upd_pending;

    // follow the same next pc the port will check against
    assign next_pc = pred_taken ? pred_pc : fetch_pc + group_bytes;

    assign push_data.pc         = fetch_pc;
    assign push_data.pred_pc    = pred_pc;
    assign push_data.pred_taken = pred_taken;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fetch_pc <= reset_pc;
        end else begin
            if (redirect)
                fetch_pc <= redirect_pc;
            else if (push)
                fetch_pc <= next_pc;
        end
    end

endmodule

// File: verilog/branch_predictor.sv
// branch predictor: btb lookup plus easy/hard direction machines picked by a hit score
`timescale 1ns/100ps

module branch_predictor (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [bp_pkg::pc_w-1:0] fetch_pc,
    output logic [bp_pkg::pc_w-1:0] pred_pc,
    output logic                    pred_taken,
    input  logic                    upd_valid,
    input  bp_pkg::update_pkt_t     upd_data,
    output logic                    upd_pop
);
    import bp_pkg::*;

    logic [(1 << index_w)-1:0] valid_mask;
    logic [1:0]                easy_state;
    logic [1:0]                easy_next;
    logic [1:0]                hard_state;
    logic [1:0]                hard_next;
    logic [1:0]                top_state;
    logic [1:0]                score;
    logic [1:0]                score_next;
    logic [index_w-1:0]        fetch_idx;
    logic [index_w-1:0]        upd_idx;
    logic [pc_w-1:0]           stored_pc;
    logic                      tgt_we;

    assign fetch_idx = fetch_pc[index_lsb +: index_w];
    assign upd_idx   = upd_data.pc[index_lsb +: index_w];
    assign tgt_we    = upd_valid && upd_data.taken && upd_data.addr_fail;
    assign upd_pop   = upd_valid;   // drain one update per cycle

    target_ram u_target_ram (
        .clk   (clk),
        .raddr (fetch_idx),
        .rdata (stored_pc),
        .waddr (upd_idx),
        .wdata (upd_data.tpc),
        .we    (tgt_we)
    );

    // unknown index falls through to the next group
    assign pred_pc = valid_mask[fetch_idx] ? stored_pc : fetch_pc + group_bytes;

    // easy machine flips to the weak state of the other side in one step
    always_comb begin
        if (upd_data.taken)
            easy_next = easy_state[1] ? strong_taken : weak_taken;
        else
            easy_next = easy_state[1] ? weak_not_taken : strong_not_taken;
    end

    always_comb begin
        case (hard_state)
            strong_taken:   hard_next = upd_data.taken ? strong_taken : weak_taken;
            weak_taken:     hard_next = upd_data.taken ? strong_taken : weak_not_taken;
            weak_not_taken: hard_next = upd_data.taken ? weak_taken : strong_not_taken;
            default:        hard_next = upd_data.taken ? weak_not_taken : strong_not_taken;
        endcase
    end

    // hits pull the score down, misses push it up
    always_comb begin
        if (!upd_data.dir_fail)
            score_next = (score == 2'b00) ? 2'b00 : score - 2'b01;
        else
            score_next = (score == 2'b11) ? 2'b11 : score + 2'b01;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_mask <= '0;
            easy_state <= weak_taken;
            hard_state <= weak_taken;
            top_state  <= top_idle;
            score      <= 2'b00;
        end else if (upd_valid) begin
            easy_state <= easy_next;
            hard_state <= hard_next;
            score      <= score_next;
            top_state  <= score_next[1] ? top_easy : top_hard;
            if (tgt_we) begin
                valid_mask[upd_idx] <= 1'b1;
            end
        end
    end

    always_comb begin
        case (top_state)
            top_easy: pred_taken = easy_state[1];
            top_hard: pred_taken = hard_state[1];
            default:  pred_taken = 1'b0;    // not taken until first update
        endcase
    end

endmodule

// File: verilog/target_ram.sv
// target ram: branch target store with one clocked write and one async read
`timescale 1ns/100ps

module target_ram (
    input  logic                       clk,
    input  logic [bp_pkg::index_w-1:0] raddr,
    output logic [bp_pkg::pc_w-1:0]    rdata,
    input  logic [bp_pkg::index_w-1:0] waddr,
    input  logic [bp_pkg::pc_w-1:0]    wdata,
    input  logic                       we
);
    import bp_pkg::*;

    logic [pc_w-1:0] mem [0:(1 << index_w)-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[raddr];  // same-cycle lookup

endmodule

// File: verilog/wb_pkg.sv
// wishbone port package: bus widths and the branch port register map
package wb_pkg;

    localparam int wb_dw = 32;
    localparam int wb_aw = 4;

    // head pc, bit 0 carries pred_taken
    localparam logic [wb_aw-1:0] reg_pc      = 4'd0;

    // head predicted pc
    localparam logic [wb_aw-1:0] reg_pred    = 4'd1;

    // write only: real next address, bit 0 carries taken
    localparam logic [wb_aw-1:0] reg_outcome = 4'd2;

endpackage

// File: verilog/bp_pkg.sv
// branch predictor package: sizes, counter encodings and the fetch/update packets
package bp_pkg;

    localparam int pc_w       = 32;
    localparam int index_w    = 8;
    localparam int index_lsb  = 3;                  // group offset bits below the index
    localparam logic [pc_w-1:0] group_bytes = 32'd8;
    localparam logic [pc_w-1:0] reset_pc    = 32'h0000_0100;
    localparam int fifo_depth = 4;
    localparam int fifo_ptr_w = $clog2(fifo_depth);

    // upper bit set means taken
    localparam logic [1:0] strong_taken     = 2'b11;
    localparam logic [1:0] weak_taken       = 2'b10;
    localparam logic [1:0] weak_not_taken   = 2'b01;
    localparam logic [1:0] strong_not_taken = 2'b00;

    localparam logic [1:0] top_idle = 2'b00;    // static not taken
    localparam logic [1:0] top_easy = 2'b01;
    localparam logic [1:0] top_hard = 2'b10;

    typedef struct packed {
        logic [pc_w-1:0] pc;
        logic [pc_w-1:0] pred_pc;
        logic            pred_taken;
    } fetch_pkt_t;

    typedef struct packed {
        logic [pc_w-1:0] pc;
        logic [pc_w-1:0] tpc;
        logic            taken;
        logic            dir_fail;
        logic            addr_fail;
    } update_pkt_t;

endpackage
